// ==== dv/bj_cases.txt ====
# bet(hex) actions(h d s, - for none) result(w l d, n = bet refused) coin_after(hex)
# cards follow the shuffle from reset, so the order of the lines matters
0 - n 1E
5 h w 2D
4 d w 35
0 - n 35
F hhs w 44
8 hs d 44
A h l 3A

// ==== tb.f ====
rtl/bj_rules_pkg.sv
rtl/bj_table_pkg.sv
rtl/card_source.sv
rtl/hand_scorer.sv
rtl/game_sequencer.sv
rtl/coin_bank.sv
rtl/blackjack_top.sv
dv/bj_clock_gen.sv
dv/bj_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= bj_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/bj_tb.sv ====
`timescale 1ns/100ps

module bj_tb;

    localparam int ROUND_CYCLES = 80;   // generous bound for one round

    logic clk, reset;
    logic next, hit, stand, double;
    logic bet_8, bet_4, bet_2, bet_1;
    bj_rules_pkg::score_t player_score, dealer_score;
    bj_rules_pkg::card_t  player_new_card, dealer_new_card;
    logic player_card_strobe, dealer_card_strobe, player_turn;
    logic win, lose, draw;
    bj_table_pkg::coin_t coin;

    int value_errors = 0;
    int other_errors = 0;
    int n_cases = 0;

    // cases read from the data file
    logic [3:0] case_bet [$];
    string      case_act [$];
    string      case_res [$];
    logic [7:0] case_coin [$];

    // reference model of cards, hands and balance
    logic [15:0]          lfsr_model;
    bj_rules_pkg::card_t  c1, c2;
    bj_rules_pkg::score_t p_sum, d_sum;
    logic                 p_ace, d_ace;
    int                   p_cnt, d_cnt, p_strobes, d_strobes;
    bj_table_pkg::coin_t  coin_model;
    bj_table_pkg::coin_t  cur_bet;

    bj_clock_gen clock_gen_i (.clk(clk), .reset(reset));

    blackjack_top blackjack_top_i (
        .clk (clk), .reset (reset), .next (next), .hit (hit), .stand (stand),
        .double (double), .bet_8 (bet_8), .bet_4 (bet_4), .bet_2 (bet_2), .bet_1 (bet_1),
        .player_score (player_score), .dealer_score (dealer_score),
        .player_new_card (player_new_card), .dealer_new_card (dealer_new_card),
        .player_card_strobe (player_card_strobe), .dealer_card_strobe (dealer_card_strobe),
        .player_turn (player_turn), .win (win), .lose (lose), .draw (draw), .coin (coin)
    );

    //----------------------------------------------------------------------
    // card rule and hand score
    //----------------------------------------------------------------------
    function automatic bj_rules_pkg::card_t card_of(input logic [3:0] nib);
        int rank;
        rank = (int'(nib) % 13) + 1;
        if (rank > 10) rank = 10;     // faces
        return bj_rules_pkg::card_t'(rank);
    endfunction

    function automatic logic [15:0] lfsr_step(input logic [15:0] v);
        return v[0] ? ((v >> 1) ^ 16'hB400) : (v >> 1);
    endfunction

    function automatic bj_rules_pkg::score_t best_score(input bj_rules_pkg::score_t sum,
                                                        input logic ace);
        if (ace && sum + 6'd10 <= 6'd21) return sum + 6'd10;
        return sum;
    endfunction

    //----------------------------------------------------------------------
    // compare tasks
    //----------------------------------------------------------------------
    task automatic check_score(input string name, input bj_rules_pkg::score_t got,
                               input bj_rules_pkg::score_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_coin(input string name, input bj_table_pkg::coin_t got,
                              input bj_table_pkg::coin_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_card(input string name, input bj_rules_pkg::card_t got,
                              input bj_rules_pkg::card_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // one-cycle pulse on a control input, driven on falling edges
    task automatic press(input byte key);
        @(negedge clk);
        case (key)
            "n": next = 1'b1;
            "h": hit = 1'b1;
            "d": double = 1'b1;
            "s": stand = 1'b1;
            default: ;
        endcase
        @(negedge clk);
        next   = 1'b0;
        hit    = 1'b0;
        double = 1'b0;
        stand  = 1'b0;
    endtask

    //----------------------------------------------------------------------
    // card monitor, one strobe is one draw
    //----------------------------------------------------------------------
    always @(negedge clk) begin
        if (!reset && (player_card_strobe || dealer_card_strobe)) begin
            c1 = card_of(lfsr_model[3:0]);
            c2 = card_of(lfsr_model[11:8]);
            if (player_card_strobe) begin
                check_card("player_new_card", player_new_card, c1);
                p_sum = p_sum + c1 + ((p_cnt == 0) ? c2 : 6'd0);
                p_ace = p_ace | (c1 == 6'd1) | ((p_cnt == 0) && (c2 == 6'd1));
                p_cnt = p_cnt + ((p_cnt == 0) ? 2 : 1);
                p_strobes++;
            end else begin
                check_card("dealer_new_card", dealer_new_card, c1);
                d_sum = d_sum + c1 + ((d_cnt == 0) ? c2 : 6'd0);
                d_ace = d_ace | (c1 == 6'd1) | ((d_cnt == 0) && (c2 == 6'd1));
                d_cnt = d_cnt + ((d_cnt == 0) ? 2 : 1);
                d_strobes++;
            end
            lfsr_model = lfsr_step(lfsr_model);
        end
    end

    task automatic run_round(input logic [3:0] bet, input string acts, input string res,
                             input bj_table_pkg::coin_t file_coin);
        bj_rules_pkg::score_t ps, ds;
        int strobes;
        logic exp_win, exp_lose, exp_draw;
        logic refused;
        @(negedge clk);
        {bet_8, bet_4, bet_2, bet_1} = bet;
        p_sum = '0;
        d_sum = '0;
        p_ace = 1'b0;
        d_ace = 1'b0;
        p_cnt = 0;
        d_cnt = 0;
        strobes = p_strobes + d_strobes;
        // zero bet or a bet above the balance is turned away
        refused = (bet == 4'h0) || (bj_table_pkg::coin_t'(bet) > coin_model);
        if ((res == "n") != refused) begin
            other_errors++;
            $display("case file marks bet %0d as %s, against the balance rule", bet, res);
        end
        if (res == "n") begin
            press("n");
            repeat (4) @(negedge clk);
            if (p_strobes + d_strobes != strobes) begin
                other_errors++;
                $display("refused bet of %0d still dealt cards", bet);
            end
            check_flag("player_turn", player_turn, 1'b0);
            check_coin("coin", coin, coin_model);
            check_coin("coin (file)", file_coin, coin_model);
            return;
        end
        cur_bet    = bj_table_pkg::coin_t'(bet);
        coin_model = coin_model - cur_bet;
        press("n");
        while (!(player_turn || win || lose || draw)) @(negedge clk);
        check_score("player_score", player_score, best_score(p_sum, p_ace));
        check_score("dealer_score", dealer_score, best_score(d_sum, d_ace));
        for (int i = 0; i < acts.len(); i++) begin
            if (acts[i] == "-" || best_score(p_sum, p_ace) >= 6'd21) break;
            if (!player_turn) begin
                other_errors++;
                $display("player turn ended before action %0d of the round", i);
                break;
            end
            press(acts[i]);
            if (acts[i] == "s") begin
                while (player_turn) @(negedge clk);
            end else begin
                while (!player_card_strobe) @(negedge clk);
                @(negedge clk);                // score settles one cycle later
                check_score("player_score", player_score, best_score(p_sum, p_ace));
                if (acts[i] == "d") begin
                    coin_model = coin_model - cur_bet;
                    cur_bet    = cur_bet + cur_bet;
                    break;
                end
            end
        end
        while (!(win || lose || draw)) @(negedge clk);

        // result against the rule on the model scores
        ps = best_score(p_sum, p_ace);
        ds = best_score(d_sum, d_ace);
        check_score("player_score", player_score, ps);
        check_score("dealer_score", dealer_score, ds);
        if (!(ds >= 6'd17 || d_cnt == 4 || ps > 6'd21)) begin
            other_errors++;
            $display("dealer stopped below 17 with %0d cards", d_cnt);
        end
        exp_lose = (ps > 6'd21) || (ds <= 6'd21 && ds > ps);
        exp_win  = !exp_lose && (ds > 6'd21 || ps > ds);
        exp_draw = !exp_lose && !exp_win;
        if ((res == "w") != exp_win || (res == "l") != exp_lose || (res == "d") != exp_draw) begin
            other_errors++;
            $display("case file result %s disagrees with the scores %0d and %0d", res, ps, ds);
        end
        check_flag("win", win, exp_win);
        check_flag("lose", lose, exp_lose);
        check_flag("draw", draw, exp_draw);

        // payout lands one cycle after the result rises
        @(negedge clk);
        if (exp_win && ps == 6'd21) coin_model = coin_model + cur_bet * 8'd4;
        else if (exp_win)           coin_model = coin_model + cur_bet * 8'd2;
        else if (exp_draw)          coin_model = coin_model + cur_bet;
        check_coin("coin", coin, coin_model);
        check_coin("coin (file)", file_coin, coin_model);

        press("n");
        check_flag("win", win, 1'b0);
        check_flag("lose", lose, 1'b0);
        check_flag("draw", draw, 1'b0);
    endtask

    //----------------------------------------------------------------------
    // watchdog
    //----------------------------------------------------------------------
    initial begin
        wait (n_cases > 0);
        repeat ((n_cases + 2) * ROUND_CYCLES) @(posedge clk);
        $display("watchdog expired, a round never finished");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        int    fd;
        string line, act, res;
        logic [3:0] b;
        logic [7:0] c;
        next   = 1'b0;
        hit    = 1'b0;
        stand  = 1'b0;
        double = 1'b0;
        {bet_8, bet_4, bet_2, bet_1} = 4'h0;
        lfsr_model = 16'hACE1;
        coin_model = 8'd30;
        p_strobes  = 0;
        d_strobes  = 0;
        p_cnt      = 0;
        d_cnt      = 0;

        fd = $fopen("dv/bj_cases.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("cannot open the cases file");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#" &&
                    $sscanf(line, "%h %s %s %h", b, act, res, c) == 4) begin
                    case_bet.push_back(b);
                    case_act.push_back(act);
                    case_res.push_back(res);
                    case_coin.push_back(c);
                end
            end
            $fclose(fd);
        end
        n_cases = case_bet.size();
        if (n_cases == 0) begin
            other_errors++;
            $display("no cases were read");
        end

        wait (!reset);
        @(negedge clk);
        check_coin("coin", coin, 8'd30);           // state after reset
        check_flag("win", win, 1'b0);
        check_flag("lose", lose, 1'b0);
        check_flag("draw", draw, 1'b0);
        check_flag("player_turn", player_turn, 1'b0);

        for (int i = 0; i < n_cases; i++) begin
            run_round(case_bet[i], case_act[i], case_res[i], case_coin[i]);
        end

        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== dv/bj_clock_gen.sv ====
`timescale 1ns/100ps

module bj_clock_gen #(
    parameter real PERIOD       = 100.0,
    parameter int  RESET_CYCLES = 8
) (
    output logic clk,
    output logic reset
);

    initial clk = 1'b0;
    always #(PERIOD / 2.0) clk = ~clk;

    // release on a falling edge, away from the DUT's sampling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// ==== rtl/blackjack_top.sv ====
`timescale 1ns/100ps

module blackjack_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 next,
    input  logic                 hit,
    input  logic                 stand,
    input  logic                 double,
    input  logic                 bet_8,
    input  logic                 bet_4,
    input  logic                 bet_2,
    input  logic                 bet_1,
    output bj_rules_pkg::score_t player_score,
    output bj_rules_pkg::score_t dealer_score,
    output bj_rules_pkg::card_t  player_new_card,
    output bj_rules_pkg::card_t  dealer_new_card,
    output logic                 player_card_strobe,
    output logic                 dealer_card_strobe,
    output logic                 player_turn,
    output logic                 win,
    output logic                 lose,
    output logic                 draw,
    output bj_table_pkg::coin_t  coin
);

    bj_rules_pkg::card_t       card1, card2;
    bj_rules_pkg::card_count_t player_count, dealer_count;
    bj_table_pkg::phase_t      phase;
    logic card_draw, bet_ok, start_round, doubled;
    logic player_clear, player_add_one, player_add_two;
    logic dealer_clear, dealer_add_one, dealer_add_two;
    logic player_twenty_one;

    assign player_twenty_one = (player_score == bj_rules_pkg::BUST_LIMIT);

    card_source card_source_i (
        .clk   (clk),
        .reset (reset),
        .draw  (card_draw),
        .card1 (card1),
        .card2 (card2)
    );

    //----------------------------------------------------------------------
    // one scorer per side
    //----------------------------------------------------------------------
    hand_scorer player_hand_i (
        .clk     (clk),
        .reset   (reset),
        .clear   (player_clear),
        .add_one (player_add_one),
        .add_two (player_add_two),
        .card1   (card1),
        .card2   (card2),
        .score   (player_score),
        .count   (player_count)
    );

    hand_scorer dealer_hand_i (
        .clk     (clk),
        .reset   (reset),
        .clear   (dealer_clear),
        .add_one (dealer_add_one),
        .add_two (dealer_add_two),
        .card1   (card1),
        .card2   (card2),
        .score   (dealer_score),
        .count   (dealer_count)
    );

    game_sequencer game_sequencer_i (
        .clk                (clk),
        .reset              (reset),
        .next               (next),
        .hit                (hit),
        .stand              (stand),
        .double             (double),
        .bet_ok             (bet_ok),
        .player_score       (player_score),
        .dealer_score       (dealer_score),
        .player_count       (player_count),
        .dealer_count       (dealer_count),
        .card1              (card1),
        .draw               (card_draw),
        .player_clear       (player_clear),
        .player_add_one     (player_add_one),
        .player_add_two     (player_add_two),
        .dealer_clear       (dealer_clear),
        .dealer_add_one     (dealer_add_one),
        .dealer_add_two     (dealer_add_two),
        .start_round        (start_round),
        .doubled            (doubled),
        .player_card_strobe (player_card_strobe),
        .dealer_card_strobe (dealer_card_strobe),
        .player_turn        (player_turn),
        .win                (win),
        .lose               (lose),
        .draw_result        (draw),
        .phase              (phase),
        .player_new_card    (player_new_card),
        .dealer_new_card    (dealer_new_card)
    );

    coin_bank coin_bank_i (
        .clk               (clk),
        .reset             (reset),
        .bet_8             (bet_8),
        .bet_4             (bet_4),
        .bet_2             (bet_2),
        .bet_1             (bet_1),
        .phase             (phase),
        .start_round       (start_round),
        .doubled           (doubled),
        .win               (win),
        .lose              (lose),
        .draw_result       (draw),
        .player_twenty_one (player_twenty_one),
        .bet_ok            (bet_ok),
        .coin              (coin)
    );

endmodule

// ==== rtl/coin_bank.sv ====
`timescale 1ns/100ps

module coin_bank (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 bet_8,
    input  logic                 bet_4,
    input  logic                 bet_2,
    input  logic                 bet_1,
    input  bj_table_pkg::phase_t phase,
    input  logic                 start_round,
    input  logic                 doubled,
    input  logic                 win,
    input  logic                 lose,
    input  logic                 draw_result,
    input  logic                 player_twenty_one,
    output logic                 bet_ok,
    output bj_table_pkg::coin_t  coin
);

    bj_table_pkg::bet_t   switch_bet, bet, bet_req;
    bj_table_pkg::phase_t last_phase;
    bj_table_pkg::coin_t  payout;
    logic                 settle;

    assign switch_bet = {1'b0, bet_8, bet_4, bet_2, bet_1};

    // switches while betting, the running bet when a double is asked
    assign bet_req = (phase == bj_table_pkg::BETTING) ? switch_bet : bet;
    assign bet_ok  = (bet_req != '0) && ({3'b000, bet_req} <= coin);

    assign settle = (phase == bj_table_pkg::RESULT) && (last_phase != bj_table_pkg::RESULT)
                    && (win || lose || draw_result);

    always_comb begin
        payout = '0;                                   // nothing back on a loss
        if (win && player_twenty_one) begin
            payout = {3'b000, bet} * bj_table_pkg::TWENTY_ONE_FACTOR;
        end else if (win) begin
            payout = {3'b000, bet} * bj_table_pkg::WIN_FACTOR;
        end else if (draw_result) begin
            payout = {3'b000, bet};
        end
    end

    always_ff @(posedge clk) begin
        if (start_round) begin
            bet <= switch_bet;
        end else if (doubled) begin
            bet <= bet + bet;
        end
    end

    //----------------------------------------------------------------------
    // balance
    //----------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            coin       <= bj_table_pkg::INITIAL_COIN;
            last_phase <= bj_table_pkg::BETTING;
        end else begin
            last_phase <= phase;
            if (start_round) begin
                coin <= coin - {3'b000, switch_bet};
            end else if (doubled) begin
                coin <= coin - {3'b000, bet};         // second stake
            end else if (settle) begin
                coin <= coin + payout;
            end
        end
    end

endmodule

// ==== rtl/game_sequencer.sv ====
`timescale 1ns/100ps

module game_sequencer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      next,
    input  logic                      hit,
    input  logic                      stand,
    input  logic                      double,
    input  logic                      bet_ok,
    input  bj_rules_pkg::score_t      player_score,
    input  bj_rules_pkg::score_t      dealer_score,
    input  bj_rules_pkg::card_count_t player_count,
    input  bj_rules_pkg::card_count_t dealer_count,
    input  bj_rules_pkg::card_t       card1,
    output logic                      draw,
    output logic                      player_clear,
    output logic                      player_add_one,
    output logic                      player_add_two,
    output logic                      dealer_clear,
    output logic                      dealer_add_one,
    output logic                      dealer_add_two,
    output logic                      start_round,
    output logic                      doubled,
    output logic                      player_card_strobe,
    output logic                      dealer_card_strobe,
    output logic                      player_turn,
    output logic                      win,
    output logic                      lose,
    output logic                      draw_result,
    output bj_table_pkg::phase_t      phase,
    output bj_rules_pkg::card_t       player_new_card,
    output bj_rules_pkg::card_t       dealer_new_card
);

    // the wait states give the scorers a cycle to register the new score
    typedef enum logic [3:0] {
        S_BET, S_DEAL_D, S_DEAL_W, S_DEAL_CHK, S_PLAY, S_PLAY_W,
        S_DBL_W, S_DEALER, S_DEALER_W, S_RESULT
    } state_t;

    state_t state, state_nxt;
    logic   lose_c, win_c;

    //----------------------------------------------------------------------
    // next state and one-cycle pulses
    //----------------------------------------------------------------------
    always_comb begin
        state_nxt      = state;
        draw           = 1'b0;
        player_clear   = 1'b0;
        player_add_one = 1'b0;
        player_add_two = 1'b0;
        dealer_clear   = 1'b0;
        dealer_add_one = 1'b0;
        dealer_add_two = 1'b0;
        start_round    = 1'b0;
        doubled        = 1'b0;
        case (state)
            S_BET: if (next && bet_ok) begin
                draw           = 1'b1;
                player_add_two = 1'b1;
                start_round    = 1'b1;
                state_nxt      = S_DEAL_D;
            end
            S_DEAL_D: begin
                draw           = 1'b1;
                dealer_add_two = 1'b1;
                state_nxt      = S_DEAL_W;
            end
            S_DEAL_W: state_nxt = S_DEAL_CHK;
            S_DEAL_CHK: begin
                state_nxt = (dealer_score == bj_rules_pkg::BUST_LIMIT) ? S_RESULT : S_PLAY;
            end
            S_PLAY: begin
                if (player_score > bj_rules_pkg::BUST_LIMIT) begin
                    state_nxt = S_RESULT;
                end else if (player_score == bj_rules_pkg::BUST_LIMIT) begin
                    state_nxt = S_DEALER;
                end else if (hit) begin           // hit > double > stand
                    if (player_count < bj_rules_pkg::MAX_CARDS) begin
                        draw           = 1'b1;
                        player_add_one = 1'b1;
                        state_nxt      = S_PLAY_W;
                    end
                end else if (double) begin
                    if (player_count == 3'd2 && bet_ok) begin
                        draw           = 1'b1;
                        player_add_one = 1'b1;
                        doubled        = 1'b1;
                        state_nxt      = S_DBL_W;
                    end
                end else if (stand) begin
                    state_nxt = S_DEALER;
                end
            end
            S_PLAY_W: state_nxt = S_PLAY;
            S_DBL_W:  state_nxt = S_DEALER;
            S_DEALER: begin
                if (dealer_score < bj_rules_pkg::DEALER_STAND &&
                    dealer_count < bj_rules_pkg::MAX_CARDS) begin
                    draw           = 1'b1;
                    dealer_add_one = 1'b1;
                    state_nxt      = S_DEALER_W;
                end else begin
                    state_nxt = S_RESULT;
                end
            end
            S_DEALER_W: state_nxt = S_DEALER;
            S_RESULT: if (next) begin
                player_clear = 1'b1;
                dealer_clear = 1'b1;
                state_nxt    = S_BET;
            end
            default: state_nxt = S_BET;
        endcase
    end

    always_comb begin
        case (state)
            S_PLAY, S_PLAY_W:                phase = bj_table_pkg::PLAYER_TURN;
            S_DBL_W, S_DEALER, S_DEALER_W:   phase = bj_table_pkg::DEALER_TURN;
            S_RESULT:                        phase = bj_table_pkg::RESULT;
            default:                         phase = bj_table_pkg::BETTING;
        endcase
    end

    assign player_turn = (phase == bj_table_pkg::PLAYER_TURN);

    //----------------------------------------------------------------------
    // outcome rule
    //----------------------------------------------------------------------
    assign lose_c = (player_score > bj_rules_pkg::BUST_LIMIT) ||
                    (dealer_score <= bj_rules_pkg::BUST_LIMIT && dealer_score > player_score);
    assign win_c  = !lose_c &&
                    (dealer_score > bj_rules_pkg::BUST_LIMIT || player_score > dealer_score);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state              <= S_BET;
            player_card_strobe <= 1'b0;
            dealer_card_strobe <= 1'b0;
            player_new_card    <= '0;
            dealer_new_card    <= '0;
            win                <= 1'b0;
            lose               <= 1'b0;
            draw_result        <= 1'b0;
        end else begin
            state              <= state_nxt;
            player_card_strobe <= player_add_one | player_add_two;
            dealer_card_strobe <= dealer_add_one | dealer_add_two;
            if (player_add_one || player_add_two) player_new_card <= card1;
            if (dealer_add_one || dealer_add_two) dealer_new_card <= card1;
            // levels rise with RESULT and hold until next
            win         <= (state_nxt == S_RESULT) && win_c;
            lose        <= (state_nxt == S_RESULT) && lose_c;
            draw_result <= (state_nxt == S_RESULT) && !win_c && !lose_c;
        end
    end

endmodule

// ==== rtl/hand_scorer.sv ====
`timescale 1ns/100ps

module hand_scorer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      clear,
    input  logic                      add_one,
    input  logic                      add_two,
    input  bj_rules_pkg::card_t       card1,
    input  bj_rules_pkg::card_t       card2,
    output bj_rules_pkg::score_t      score,
    output bj_rules_pkg::card_count_t count
);

    bj_rules_pkg::card_t  cards [0:3];
    bj_rules_pkg::score_t sum;
    logic                 has_ace;

    // card slots are payload, only count says which are live
    always_ff @(posedge clk) begin
        if (add_one && count < bj_rules_pkg::MAX_CARDS) begin
            cards[count[1:0]] <= card1;
        end else if (add_two && count <= bj_rules_pkg::MAX_CARDS - 3'd2) begin
            cards[count[1:0]]        <= card1;
            cards[count[1:0] + 2'd1] <= card2;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (add_one && count < bj_rules_pkg::MAX_CARDS) begin
            count <= count + 3'd1;
        end else if (add_two && count <= bj_rules_pkg::MAX_CARDS - 3'd2) begin
            count <= count + 3'd2;
        end
    end

    //----------------------------------------------------------------------
    // score, one ace may count as 11
    //----------------------------------------------------------------------
    always_comb begin
        sum     = '0;
        has_ace = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (bj_rules_pkg::card_count_t'(i) < count) begin
                sum = sum + cards[i];
                if (cards[i] == 6'd1) has_ace = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            score <= '0;
        end else if (has_ace && sum + bj_rules_pkg::ACE_BONUS <= bj_rules_pkg::BUST_LIMIT) begin
            score <= sum + bj_rules_pkg::ACE_BONUS;
        end else begin
            score <= sum;
        end
    end

endmodule

// ==== rtl/card_source.sv ====
`timescale 1ns/100ps

module card_source (
    input  logic                clk,
    input  logic                reset,
    input  logic                draw,
    output bj_rules_pkg::card_t card1,
    output bj_rules_pkg::card_t card2
);

    logic [15:0] lfsr;

    // nibble -> rank 1..13 -> card value with faces capped
    function automatic bj_rules_pkg::card_t nibble_to_card(input logic [3:0] nib);
        logic [3:0] rank;
        rank = (nib % 4'd13) + 4'd1;
        if ({2'b00, rank} > bj_rules_pkg::FACE_VALUE) begin
            return bj_rules_pkg::FACE_VALUE;
        end
        return {2'b00, rank};
    endfunction

    assign card1 = nibble_to_card(lfsr[3:0]);
    assign card2 = nibble_to_card(lfsr[11:8]);   // third nibble

    //----------------------------------------------------------------------
    // galois step, taps 16 14 13 11
    //----------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr <= bj_rules_pkg::LFSR_SEED;
        end else if (draw) begin
            lfsr <= {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hB400 : 16'h0000);
        end
    end

endmodule

// ==== rtl/bj_table_pkg.sv ====
package bj_table_pkg;

    // round phase as seen by the coin bank and the outside
    typedef enum logic [1:0] {
        BETTING     = 2'd0,
        PLAYER_TURN = 2'd1,
        DEALER_TURN = 2'd2,
        RESULT      = 2'd3
    } phase_t;

    typedef logic [7:0] coin_t;
    typedef logic [4:0] bet_t;   // wide enough for a doubled bet of 15

    //----------------------------------------------------------------------
    // balance and payout
    //----------------------------------------------------------------------
    localparam coin_t INITIAL_COIN      = 8'd30;
    localparam coin_t WIN_FACTOR        = 8'd2;
    localparam coin_t TWENTY_ONE_FACTOR = 8'd4;  // winning hand at exactly 21

endpackage

// ==== rtl/bj_rules_pkg.sv ====
package bj_rules_pkg;

    //----------------------------------------------------------------------
    // card and hand types
    //----------------------------------------------------------------------
    typedef logic [5:0] card_t;        // 1..10, 1 is an ace
    typedef logic [5:0] score_t;
    typedef logic [2:0] card_count_t;  // 0..4 cards held

    //----------------------------------------------------------------------
    // game rule constants
    //----------------------------------------------------------------------
    localparam card_count_t MAX_CARDS = 3'd4;

    localparam score_t BUST_LIMIT   = 6'd21;
    localparam score_t DEALER_STAND = 6'd17;  // dealer stops drawing here
    localparam score_t ACE_BONUS    = 6'd10;  // one ace counted as 11

    // ranks 11 to 13 are face cards, all worth ten
    localparam card_t FACE_VALUE = 6'd10;

    localparam logic [15:0] LFSR_SEED = 16'hACE1;

endpackage
